// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timescale 1ns/1ps -j 0
TOP       = tb_mips_core
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard src/*.sv src/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
+incdir+src
src/mips_pkg.sv
src/mips_pipe_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_writeback.sv
src/mips_core.sv
tb/tb_mips_core.sv

// ==== src/decode_stage.sv ====
`include "mips_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic                        i_run,
    input  logic [`MIPS_NB_DATA-1:0]    i_instruction,
    input  logic                        i_wb_reg_write,
    input  logic [`MIPS_NB_REG-1:0]     i_wb_dest,
    input  logic [`MIPS_NB_DATA-1:0]    i_wb_data,
    input  logic [`MIPS_NB_REG-1:0]     i_rb_address,
    output logic                        o_stall,
    output logic [`MIPS_NB_DATA-1:0]    o_rb_data,
    id_ex_if.decode_mp                  id_ex
);
    import mips_pkg::*;

    opcode_e                   opcode;
    funct_e                    funct;
    logic [`MIPS_NB_REG-1:0]   rs;
    logic [`MIPS_NB_REG-1:0]   rt;
    logic [`MIPS_NB_REG-1:0]   rd;
    logic [`MIPS_NB_DATA-1:0]  imm_ext;
    logic [`MIPS_NB_DATA-1:0]  regs [2**`MIPS_NB_REG];

    logic                      c_reg_write;
    logic                      c_mem_read;
    logic                      c_mem_write;
    logic                      c_mem_to_reg;
    logic                      c_alu_src;
    logic                      c_reg_dest;
    logic                      c_hlt;
    alu_op_e                   c_alu_op;

    logic                      load_use;
    logic                      halted;
    logic                      bubble;

    assign opcode  = opcode_e'(i_instruction[31:26]);
    assign funct   = funct_e'(i_instruction[5:0]);
    assign rs      = i_instruction[25:21];
    assign rt      = i_instruction[20:16];
    assign rd      = i_instruction[15:11];
    assign imm_ext = {{(`MIPS_NB_DATA-16){i_instruction[15]}}, i_instruction[15:0]};

    always_comb begin
        c_reg_write  = 1'b0;
        c_mem_read   = 1'b0;
        c_mem_write  = 1'b0;
        c_mem_to_reg = 1'b0;
        c_alu_src    = 1'b0;
        c_reg_dest   = 1'b0;
        c_hlt        = 1'b0;
        c_alu_op     = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                c_reg_write = 1'b1;
                c_reg_dest  = 1'b1;
                case (funct)
                    FN_ADD:  c_alu_op = ALU_ADD;
                    FN_SUB:  c_alu_op = ALU_SUB;
                    FN_AND:  c_alu_op = ALU_AND;
                    FN_OR:   c_alu_op = ALU_OR;
                    FN_SLT:  c_alu_op = ALU_SLT;
                    default: c_reg_write = 1'b0;             // All-zero word is a nop
                endcase
            end
            OP_ADDI: begin
                c_reg_write = 1'b1;
                c_alu_src   = 1'b1;
            end
            OP_LW: begin
                c_reg_write  = 1'b1;
                c_mem_read   = 1'b1;
                c_mem_to_reg = 1'b1;
                c_alu_src    = 1'b1;
            end
            OP_SW: begin
                c_mem_write = 1'b1;
                c_alu_src   = 1'b1;
            end
            OP_HALT: c_hlt = 1'b1;
            default: ;
        endcase
    end

    // Same-cycle writeback is bypassed to the reader
    function automatic logic [`MIPS_NB_DATA-1:0] read_reg(input logic [`MIPS_NB_REG-1:0] addr);
        logic [`MIPS_NB_DATA-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (i_wb_reg_write && i_wb_dest == addr) begin
            value = i_wb_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge i_clock) begin
        if (i_run && i_wb_reg_write && i_wb_dest != '0) begin
            regs[i_wb_dest] <= i_wb_data;
        end
    end

    always_comb begin
        o_rb_data = read_reg(i_rb_address);
    end

    assign load_use = id_ex.mem_read && (id_ex.rt == rs || id_ex.rt == rt);
    assign bubble   = load_use || halted;
    assign o_stall  = load_use || halted || c_hlt;   // Halt freezes fetch for good

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            halted <= 1'b0;
        end else if (i_run && c_hlt && !load_use) begin
            halted <= 1'b1;                          // Halt itself goes on to EX
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            id_ex.reg_write  <= 1'b0;
            id_ex.mem_read   <= 1'b0;
            id_ex.mem_write  <= 1'b0;
            id_ex.mem_to_reg <= 1'b0;
            id_ex.alu_src    <= 1'b0;
            id_ex.reg_dest   <= 1'b0;
            id_ex.hlt        <= 1'b0;
        end else if (i_run) begin
            id_ex.reg_write  <= c_reg_write && !bubble;
            id_ex.mem_read   <= c_mem_read && !bubble;
            id_ex.mem_write  <= c_mem_write && !bubble;
            id_ex.mem_to_reg <= c_mem_to_reg && !bubble;
            id_ex.alu_src    <= c_alu_src && !bubble;
            id_ex.reg_dest   <= c_reg_dest && !bubble;
            id_ex.hlt        <= c_hlt && !bubble;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run) begin
            id_ex.alu_op    <= c_alu_op;
            id_ex.data_a    <= read_reg(rs);
            id_ex.data_b    <= read_reg(rt);
            id_ex.immediate <= imm_ext;
            id_ex.rs        <= rs;
            id_ex.rt        <= rt;
            id_ex.rd        <= rd;
        end
    end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`include "mips_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic                        i_run,
    input  logic                        i_wb_reg_write,
    input  logic [`MIPS_NB_REG-1:0]     i_wb_dest,
    input  logic [`MIPS_NB_DATA-1:0]    i_wb_data,
    id_ex_if.execute_mp                 id_ex,
    ex_mem_if.execute_mp                ex_mem
);
    import mips_pkg::*;

    fwd_sel_e                  fwd_a;
    fwd_sel_e                  fwd_b;
    logic [`MIPS_NB_DATA-1:0]  opnd_a;
    logic [`MIPS_NB_DATA-1:0]  opnd_b;
    logic [`MIPS_NB_DATA-1:0]  alu_in_b;
    logic [`MIPS_NB_DATA-1:0]  alu_out;
    logic [`MIPS_NB_REG-1:0]   dest;

    // Younger result in MEM wins over WB
    function automatic fwd_sel_e pick_fwd(input logic [`MIPS_NB_REG-1:0] src,
                                          input logic mem_we,
                                          input logic [`MIPS_NB_REG-1:0] mem_dest,
                                          input logic wb_we,
                                          input logic [`MIPS_NB_REG-1:0] wb_dest);
        fwd_sel_e sel;
        if (mem_we && mem_dest != '0 && mem_dest == src) begin
            sel = FWD_MEM;
        end else if (wb_we && wb_dest != '0 && wb_dest == src) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    function automatic logic [`MIPS_NB_DATA-1:0] fwd_value(input fwd_sel_e sel,
                                                           input logic [`MIPS_NB_DATA-1:0] reg_val,
                                                           input logic [`MIPS_NB_DATA-1:0] mem_val,
                                                           input logic [`MIPS_NB_DATA-1:0] wb_val);
        logic [`MIPS_NB_DATA-1:0] value;
        case (sel)
            FWD_MEM: value = mem_val;
            FWD_WB:  value = wb_val;
            default: value = reg_val;
        endcase
        return value;
    endfunction

    assign fwd_a = pick_fwd(id_ex.rs, ex_mem.reg_write, ex_mem.dest, i_wb_reg_write, i_wb_dest);
    assign fwd_b = pick_fwd(id_ex.rt, ex_mem.reg_write, ex_mem.dest, i_wb_reg_write, i_wb_dest);

    assign opnd_a   = fwd_value(fwd_a, id_ex.data_a, ex_mem.alu_result, i_wb_data);
    assign opnd_b   = fwd_value(fwd_b, id_ex.data_b, ex_mem.alu_result, i_wb_data);
    assign alu_in_b = id_ex.alu_src ? id_ex.immediate : opnd_b;
    assign dest     = id_ex.reg_dest ? id_ex.rd : id_ex.rt;

    always_comb begin
        case (alu_op_e'(id_ex.alu_op))
            ALU_SUB: alu_out = opnd_a - alu_in_b;
            ALU_AND: alu_out = opnd_a & alu_in_b;
            ALU_OR:  alu_out = opnd_a | alu_in_b;
            ALU_SLT: alu_out = {{(`MIPS_NB_DATA-1){1'b0}}, $signed(opnd_a) < $signed(alu_in_b)};
            default: alu_out = opnd_a + alu_in_b;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            ex_mem.reg_write  <= 1'b0;
            ex_mem.mem_read   <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
            ex_mem.hlt        <= 1'b0;
        end else if (i_run) begin
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.mem_to_reg <= id_ex.mem_to_reg;
            ex_mem.hlt        <= id_ex.hlt;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run) begin
            ex_mem.alu_result <= alu_out;
            ex_mem.store_data <= opnd_b;         // Forwarded rt for sw
            ex_mem.dest       <= dest;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
`include "mips_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                         i_clock,
    input  logic                         i_rst_n,
    input  logic                         i_run,
    input  logic                         i_stall,
    input  logic                         i_im_write_enable,
    input  logic [`MIPS_NB_IM_ADDR-1:0]  i_im_address,
    input  logic [`MIPS_NB_BYTE-1:0]     i_im_data,
    output logic [`MIPS_NB_DATA-1:0]     o_pc,
    output logic [`MIPS_NB_DATA-1:0]     o_instruction
);
    logic [`MIPS_NB_BYTE-1:0]    imem [2**`MIPS_NB_IM_ADDR];
    logic [`MIPS_NB_DATA-1:0]    pc;
    logic [`MIPS_NB_DATA-1:0]    fetched;
    logic [`MIPS_NB_IM_ADDR-1:0] byte_addr [4];

    // Program is loaded a byte at a time while the core is idle
    always_ff @(posedge i_clock) begin
        if (i_im_write_enable && !i_run) begin
            imem[i_im_address] <= i_im_data;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            byte_addr[i] = pc[`MIPS_NB_IM_ADDR-1:0] + `MIPS_NB_IM_ADDR'(i);
        end
        fetched = {imem[byte_addr[0]], imem[byte_addr[1]],
                   imem[byte_addr[2]], imem[byte_addr[3]]};   // Big endian
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            pc            <= '0;
            o_instruction <= '0;                             // Nop
        end else if (i_run && !i_stall) begin
            pc            <= pc + `MIPS_NB_DATA'(4);
            o_instruction <= fetched;
        end
    end

    assign o_pc = pc;

endmodule

`default_nettype wire

// ==== src/memory_writeback.sv ====
`include "mips_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module memory_writeback (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic                        i_run,
    ex_mem_if.memory_mp                 ex_mem,
    output logic                        o_wb_reg_write,
    output logic [`MIPS_NB_REG-1:0]     o_wb_dest,
    output logic [`MIPS_NB_DATA-1:0]    o_wb_data,
    output logic                        o_hlt
);
    logic [`MIPS_NB_DATA-1:0]     dmem [2**`MIPS_NB_DM_ADDR];
    logic [`MIPS_NB_DM_ADDR-1:0]  dm_addr;
    logic                         wb_mem_to_reg;
    logic [`MIPS_NB_DATA-1:0]     wb_alu_result;
    logic [`MIPS_NB_DATA-1:0]     wb_load_data;

    assign dm_addr = ex_mem.alu_result[`MIPS_NB_DM_ADDR+1:2];   // Word address

    always_ff @(posedge i_clock) begin
        if (i_run && ex_mem.mem_write) begin
            dmem[dm_addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_wb_reg_write <= 1'b0;
            wb_mem_to_reg  <= 1'b0;
            o_hlt          <= 1'b0;
        end else if (i_run) begin
            o_wb_reg_write <= ex_mem.reg_write;
            wb_mem_to_reg  <= ex_mem.mem_to_reg;
            o_hlt          <= o_hlt || ex_mem.hlt;        // Sticky until reset
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run) begin
            o_wb_dest     <= ex_mem.dest;
            wb_alu_result <= ex_mem.alu_result;
            if (ex_mem.mem_read) begin
                wb_load_data <= dmem[dm_addr];
            end
        end
    end

    assign o_wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

`default_nettype wire

// ==== src/mips_core.sv ====
`include "mips_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic                         i_clock,
    input  logic                         i_rst_n,
    input  logic                         i_run,
    input  logic                         i_im_write_enable,
    input  logic [`MIPS_NB_IM_ADDR-1:0]  i_im_address,
    input  logic [`MIPS_NB_BYTE-1:0]     i_im_data,
    input  logic [`MIPS_NB_REG-1:0]      i_rb_address,
    output logic [`MIPS_NB_DATA-1:0]     o_pc_value,
    output logic [`MIPS_NB_DATA-1:0]     o_rb_data,
    output logic                         o_hlt
);
    logic [`MIPS_NB_DATA-1:0]  if_instruction;
    logic                      stall;
    logic                      wb_reg_write;
    logic [`MIPS_NB_REG-1:0]   wb_dest;
    logic [`MIPS_NB_DATA-1:0]  wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    fetch_stage fetch0 (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_run             (i_run),
        .i_stall           (stall),
        .i_im_write_enable (i_im_write_enable),
        .i_im_address      (i_im_address),
        .i_im_data         (i_im_data),
        .o_pc              (o_pc_value),
        .o_instruction     (if_instruction)
    );

    decode_stage decode0 (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_run          (i_run),
        .i_instruction  (if_instruction),
        .i_wb_reg_write (wb_reg_write),
        .i_wb_dest      (wb_dest),
        .i_wb_data      (wb_data),
        .i_rb_address   (i_rb_address),
        .o_stall        (stall),
        .o_rb_data      (o_rb_data),
        .id_ex          (id_ex.decode_mp)
    );

    execute_stage execute0 (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_run          (i_run),
        .i_wb_reg_write (wb_reg_write),
        .i_wb_dest      (wb_dest),
        .i_wb_data      (wb_data),
        .id_ex          (id_ex.execute_mp),
        .ex_mem         (ex_mem.execute_mp)
    );

    memory_writeback memwb0 (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_run          (i_run),
        .ex_mem         (ex_mem.memory_mp),
        .o_wb_reg_write (wb_reg_write),
        .o_wb_dest      (wb_dest),
        .o_wb_data      (wb_data),
        .o_hlt          (o_hlt)
    );

endmodule

`default_nettype wire

// ==== src/mips_pipe_if.sv ====
`include "mips_settings.svh"
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;
    logic                        reg_write;
    logic                        mem_read;
    logic                        mem_write;
    logic                        mem_to_reg;
    logic                        alu_src;
    logic                        reg_dest;
    logic                        hlt;
    logic [`MIPS_NB_ALU_OP-1:0]  alu_op;
    logic [`MIPS_NB_DATA-1:0]    data_a;
    logic [`MIPS_NB_DATA-1:0]    data_b;
    logic [`MIPS_NB_DATA-1:0]    immediate;
    logic [`MIPS_NB_REG-1:0]     rs;
    logic [`MIPS_NB_REG-1:0]     rt;
    logic [`MIPS_NB_REG-1:0]     rd;

    modport decode_mp (output reg_write, mem_read, mem_write, mem_to_reg, alu_src,
                       reg_dest, hlt, alu_op, data_a, data_b, immediate, rs, rt, rd);
    modport execute_mp (input reg_write, mem_read, mem_write, mem_to_reg, alu_src,
                        reg_dest, hlt, alu_op, data_a, data_b, immediate, rs, rt, rd);
endinterface

interface ex_mem_if;
    logic                        reg_write;
    logic                        mem_read;
    logic                        mem_write;
    logic                        mem_to_reg;
    logic                        hlt;
    logic [`MIPS_NB_DATA-1:0]    alu_result;
    logic [`MIPS_NB_DATA-1:0]    store_data;
    logic [`MIPS_NB_REG-1:0]     dest;

    modport execute_mp (output reg_write, mem_read, mem_write, mem_to_reg, hlt,
                        alu_result, store_data, dest);
    modport memory_mp (input reg_write, mem_read, mem_write, mem_to_reg, hlt,
                       alu_result, store_data, dest);
endinterface

`default_nettype wire

// ==== src/mips_pkg.sv ====
`include "mips_settings.svh"
`default_nettype none

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = `MIPS_OP_HALT
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [`MIPS_NB_ALU_OP-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,                         // Register file value
        FWD_MEM,                         // EX/MEM ALU result
        FWD_WB                           // Writeback data
    } fwd_sel_e;

endpackage

`default_nettype wire

// ==== src/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

`default_nettype none

`define MIPS_NB_DATA     32
`define MIPS_NB_REG      5
`define MIPS_NB_IM_ADDR  8           // 256 bytes of program
`define MIPS_NB_DM_ADDR  5           // 32 data words
`define MIPS_NB_BYTE     8
`define MIPS_NB_ALU_OP   3
`define MIPS_OP_HALT     6'b111111

`default_nettype wire

`endif

// ==== tb/mips_tests.txt ====
# test <name> <word count>, then one line per instruction: word <hex>
# check <register> <expected hex> per register to read back, closed by: end
test alu_ops 11
word 2001000C
word 2002FFFB
word 200300F0
word 2004003C
word 00222820
word 00223022
word 00643824
word 00644025
word 0041482A
word 0022502A
word FC000000
check 1 0000000C
check 2 FFFFFFFB
check 5 00000007
check 6 00000011
check 7 00000030
check 8 000000FC
check 9 00000001
check 10 00000000
end
test forwarding 7
word 20010003
word 20220004
word 00221820
word 20010014
word 20210005
word 00202020
word FC000000
check 1 00000019
check 2 00000007
check 3 0000000A
check 4 00000019
end
test store_load 9
word 20010055
word 20020066
word AC010008
word AC02000C
word 20010000
word 20020000
word 8C030008
word 8C04000C
word FC000000
check 1 00000000
check 2 00000000
check 3 00000055
check 4 00000066
end
test load_use 7
word 20010028
word AC010010
word 8C020010
word 20430002
word 8C040010
word 00842820
word FC000000
check 2 00000028
check 3 0000002A
check 4 00000028
check 5 00000050
end
test zero_reg 4
word 20000009
word 00000820
word 20020007
word FC000000
check 0 00000000
check 1 00000000
check 2 00000007
end
test halt_freeze 5
word 20050007
word 20060001
word FC000000
word 20050009
word 20060002
check 5 00000007
check 6 00000001
end

// ==== tb/tb_mips_core.sv ====
`include "mips_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
    localparam int HALT_TIMEOUT  = 400;     // Cycles from run to o_hlt
    localparam int FREEZE_CYCLES = 6;

    logic                         clock;
    logic                         rst_n;
    logic                         run;
    logic                         im_write_enable;
    logic [`MIPS_NB_IM_ADDR-1:0]  im_address;
    logic [`MIPS_NB_BYTE-1:0]     im_data;
    logic [`MIPS_NB_REG-1:0]      rb_address;
    logic [`MIPS_NB_DATA-1:0]     pc_value;
    logic [`MIPS_NB_DATA-1:0]     rb_data;
    logic                         hlt;

    logic [`MIPS_NB_DATA-1:0]     program_words [$];
    int                           check_regs [$];
    logic [`MIPS_NB_DATA-1:0]     check_values [$];
    int                           tests_run;

    mips_core dut0 (
        .i_clock           (clock),
        .i_rst_n           (rst_n),
        .i_run             (run),
        .i_im_write_enable (im_write_enable),
        .i_im_address      (im_address),
        .i_im_data         (im_data),
        .i_rb_address      (rb_address),
        .o_pc_value        (pc_value),
        .o_rb_data         (rb_data),
        .o_hlt             (hlt)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Test run aborted");
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [`MIPS_NB_DATA-1:0] expected,
                               input logic [`MIPS_NB_DATA-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch test %s %s expected %h actual %h",
                                test_name, what, expected, actual));
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (8) @(negedge clock);
        rst_n = 1'b1;
    endtask

    task automatic load_program();
        foreach (program_words[i]) begin
            for (int b = 0; b < 4; b++) begin
                @(negedge clock);
                im_write_enable = 1'b1;
                im_address      = `MIPS_NB_IM_ADDR'(4 * i + b);
                im_data         = program_words[i][31 - 8 * b -: 8];   // MSB first
            end
        end
        @(negedge clock);
        im_write_enable = 1'b0;
    endtask

    task automatic wait_for_halt(input string test_name);
        int cycles;
        cycles = 0;
        while (!hlt) begin
            @(negedge clock);
            cycles++;
            if (cycles > HALT_TIMEOUT) begin
                abort_run($sformatf("Test %s timed out waiting for the halt flag", test_name));
            end
        end
    endtask

    task automatic check_registers(input string test_name);
        foreach (check_regs[i]) begin
            @(negedge clock);
            rb_address = `MIPS_NB_REG'(check_regs[i]);
            @(negedge clock);
            check_value(test_name, $sformatf("r%0d", check_regs[i]), check_values[i], rb_data);
        end
    endtask

    task automatic run_test(input string test_name, input int count);
        int                       halt_index;
        logic [`MIPS_NB_DATA-1:0] frozen_pc;
        halt_index = -1;
        if (count != program_words.size()) begin
            abort_run($sformatf("Test %s declares %0d words but lists %0d",
                                test_name, count, program_words.size()));
        end
        foreach (program_words[i]) begin
            if (halt_index < 0 && program_words[i][31:26] == `MIPS_OP_HALT) begin
                halt_index = i;
            end
        end
        if (halt_index < 0) begin
            abort_run($sformatf("Test %s has no halt instruction", test_name));
        end
        frozen_pc = `MIPS_NB_DATA'(4 * (halt_index + 1));   // Halt sits in IF/ID
        @(negedge clock);
        run = 1'b0;
        load_program();
        apply_reset();
        check_value(test_name, "hlt", 1'b0, hlt);
        run = 1'b1;
        wait_for_halt(test_name);
        repeat (FREEZE_CYCLES) begin
            @(negedge clock);
            check_value(test_name, "pc", frozen_pc, pc_value);
            check_value(test_name, "hlt", 1'b1, hlt);
        end
        check_registers(test_name);
        run = 1'b0;
    endtask

    initial begin
        int                       fd;
        int                       n;
        int                       count;
        int                       index;
        string                    line;
        string                    kw;
        string                    test_name;
        logic [`MIPS_NB_DATA-1:0] value;
        rst_n           = 1'b0;
        run             = 1'b0;
        im_write_enable = 1'b0;
        im_address      = '0;
        im_data         = '0;
        rb_address      = '0;
        tests_run       = 0;
        count           = 0;
        test_name       = "none";
        fd = $fopen("tb/mips_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open tb/mips_tests.txt");
        end
        apply_reset();
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", kw);
            if (n < 1 || kw == "#") begin
                continue;
            end
            if (kw == "test") begin
                void'($sscanf(line, "%s %s %d", kw, test_name, count));
                program_words.delete();
                check_regs.delete();
                check_values.delete();
            end else if (kw == "word") begin
                void'($sscanf(line, "%s %h", kw, value));
                program_words.push_back(value);
            end else if (kw == "check") begin
                void'($sscanf(line, "%s %d %h", kw, index, value));
                check_regs.push_back(index);
                check_values.push_back(value);
            end else if (kw == "end") begin
                run_test(test_name, count);
                tests_run++;
            end else begin
                abort_run($sformatf("Unknown line in test file: %s", line));
            end
        end
        $fclose(fd);
        if (tests_run > 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("No tests were found in tb/mips_tests.txt");
        end
    end

endmodule

`default_nettype wire
